//--- issuer.f
+incdir+source
source/issuer_pkg.sv
source/dep_fifo.sv
source/inflight_table.sv
source/proc_driver.sv
source/issue_ctrl.sv
source/issuer_top.sv
testbench/tb_clkgen.sv
testbench/issuer_assert.sv
testbench/issuer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the issuer testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module issuer_tb -f issuer.f -o Vissuer_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vissuer_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

//--- testbench/issuer_tb.sv
/*
    Command issuer testbench.
    Models the command queue and the processors, tracks in-flight ids
    and checks enables, instruction beats and finish acks.
*/
`timescale 1ns/1ps
`default_nettype none

module issuer_tb;

    logic                    clk, rstn;
    issuer_pkg::cmd_t        cmd_in;
    logic                    empty_q, rd_q, fin_task;
    issuer_pkg::proc_mask_t  busy, fin, en, ack;
    issuer_pkg::proc_mask_t  fin_seen;       // finish bits of the previous cycle
    issuer_pkg::instr_t      instr;

    issuer_pkg::cmd_t  q_cmds[$];      // queue model
    issuer_pkg::cmd_t  pending[$];     // read but not yet enabled
    int                pst[4];         // 0 idle, 1 running, 2 finishing
    int                pcnt[4];
    logic              fl_valid[4];    // in-flight id per processor
    logic [4:0]        fl_id[4];
    logic [4:0]        next_id, hist[$];
    int                beat_left, beat_proc, enabled, err_cnt, cycles, limit;
    logic              beat_found, last_fin_task, verdict_done;
    issuer_pkg::cmd_t  beat_cmd;
    string             test_name;
    int unsigned       seed_dummy;

    tb_clkgen u_clkgen (.o_clk(clk), .o_rstn(rstn));

    issuer_top dut (
        .i_clk(clk), .i_rstn(rstn), .i_cmd(cmd_in), .i_empty_queue(empty_q),
        .o_rd_queue(rd_q), .i_busy_proc(busy), .i_finish_proc(fin),
        .o_en_proc(en), .o_ack_proc(ack), .o_instr(instr), .o_finished_task(fin_task)
    );

    task automatic check_instr(input issuer_pkg::instr_t exp, input issuer_pkg::instr_t act);
        if (exp !== act) begin
            $display("[FAIL] %s instr expected %h actual %h", test_name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_mask(input issuer_pkg::proc_mask_t exp,
                              input issuer_pkg::proc_mask_t act);
        if (exp !== act) begin
            $display("[FAIL] %s mask expected %b actual %b", test_name, exp, act);
            err_cnt++;
        end
    endtask

    function automatic issuer_pkg::proc_mask_t lowest_bit(input issuer_pkg::proc_mask_t m);
        for (int i = 0; i < 4; i++) begin
            if (m[i]) return issuer_pkg::proc_mask_t'(1 << i);
        end
        return '0;
    endfunction

    function automatic issuer_pkg::instr_t beat_of(input issuer_pkg::cmd_info_t inf, input int k);
        issuer_pkg::instr_t b;
        case (k)
            0:       b = {issuer_pkg::LD, inf.addr_0};
            1:       b = {issuer_pkg::LD, inf.addr_1};
            2:       b = {issuer_pkg::INFO, inf.op, inf.count};  // op then count
            default: b = {issuer_pkg::STORE, inf.wr_addr};
        endcase
        return b;
    endfunction

    // one beat of an issue, the LD addr_0 beat names the command
    task automatic take_beat();
        int k;
        int idx;
        k = 4 - beat_left;
        check_mask(issuer_pkg::proc_mask_t'(1 << beat_proc), ack);
        if (k == 0) begin
            idx = -1;
            foreach (pending[i]) begin
                if (idx < 0 && pending[i].id == instr.payload[7:3]) idx = i;
            end
            beat_found = (idx >= 0);
            if (!beat_found) begin
                $display("%s: issued command id %0d was never read", test_name,
                         instr.payload[7:3]);
                err_cnt++;
            end else begin
                beat_cmd = pending[idx];
                pending.delete(idx);
                for (int p = 0; p < 4; p++) begin
                    if (fl_valid[p] && beat_cmd.dep != 0 && fl_id[p] == beat_cmd.dep) begin
                        $display("%s: command %0d issued while dependency %0d in flight",
                                 test_name, beat_cmd.id, beat_cmd.dep);
                        err_cnt++;
                    end
                end
                fl_valid[beat_proc] = 1'b1;
                fl_id[beat_proc]    = beat_cmd.id;
                enabled++;
            end
        end
        if (beat_found) check_instr(beat_of(beat_cmd.info, k), instr);
        beat_left--;
    endtask

    task automatic run_cycle();
        int p;
        @(negedge clk);
        cycles++;
        last_fin_task = fin_task;
        if (fin_task && (busy != '0 || pending.size() != 0 || beat_left > 0)) begin
            $display("%s: all-idle flag high while work is outstanding", test_name);
            err_cnt++;
        end
        if (rd_q) begin
            if (q_cmds.size() == 0) begin
                $display("%s: queue read while empty", test_name);
                err_cnt++;
            end else begin
                pending.push_back(q_cmds.pop_front());
            end
        end
        if (beat_left > 0) begin
            take_beat();
        end else if (ack != '0) begin
            if (fin_seen == '0) begin
                $display("%s: ack with no processor finishing", test_name);
                err_cnt++;
            end
            check_mask(lowest_bit(fin_seen), ack);   // lowest finisher seen at the flush
            for (int i = 0; i < 4; i++) begin
                if (ack[i]) begin
                    pst[i]      = 0;
                    fl_valid[i] = 1'b0;
                end
            end
        end
        fin_seen = fin;
        for (int i = 0; i < 4; i++) begin
            if (pst[i] == 1) begin
                pcnt[i]--;
                if (pcnt[i] == 0) pst[i] = 2;
            end
        end
        if (en != '0) begin
            p = 0;
            for (int i = 3; i >= 0; i--) if (en[i]) p = i;
            if (!$onehot(en) || pst[p] != 0 || busy[p] || fl_valid[p]) begin
                $display("%s: enable %b to a busy processor or not one-hot",
                         test_name, en);
                err_cnt++;
            end
            beat_left = 4;
            beat_proc = p;
            pst[p]    = 1;
            pcnt[p]   = 4 + 3 + int'($urandom % 10);  // 3 to 12 after the beats
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < 4; i++) begin
            busy[i] = (pst[i] != 0);
            fin[i]  = (pst[i] == 2);
        end
        empty_q = (q_cmds.size() == 0);
        cmd_in  = empty_q ? '0 : q_cmds[0];
    endtask

    // cycle limit of the running test
    always @(posedge clk) begin
        if (cycles > limit) begin
            $display("%s: timeout after %0d cycles", test_name, cycles);
            verdict_done = 1'b1;
            $display("Finished with errors");
            $finish;
        end
    end

    // run stopped before the last test finished
    final begin
        if (!verdict_done) $display("Finished with errors");
    end

    function automatic issuer_pkg::cmd_t make_cmd(input logic [4:0] dep);
        issuer_pkg::cmd_t c;
        c.id           = next_id;
        c.dep          = dep;
        c.info.op      = 3'($urandom);
        c.info.addr_0  = {next_id, 3'($urandom)};   // id travels in the first beat
        c.info.addr_1  = 8'($urandom);
        c.info.wr_addr = 8'($urandom);
        c.info.count   = 5'($urandom);
        next_id        = (next_id == 5'd31) ? 5'd1 : next_id + 5'd1;
        return c;
    endfunction

    // mode 0 independent, 1 chain on previous, 2 random mix
    task automatic run_test(input string name, input int n, input int mode);
        int errs0;
        logic [4:0] dep;
        logic done;
        test_name = name;
        errs0     = err_cnt;
        cycles    = 0;
        limit     = 60 * n;
        enabled   = 0;
        hist.delete();
        for (int i = 0; i < n; i++) begin
            dep = 5'd0;
            if (mode == 1 && hist.size() > 0) dep = hist[$];
            if (mode == 2 && hist.size() > 0 && ($urandom % 2) == 1) begin
                dep = hist[$urandom % hist.size()];
            end
            hist.push_back(next_id);
            if (hist.size() > 3) void'(hist.pop_front());
            q_cmds.push_back(make_cmd(dep));
        end
        done = 1'b0;
        while (!done) begin
            run_cycle();
            done = (q_cmds.size() == 0) && (pending.size() == 0) && (beat_left == 0)
                   && (pst[0] == 0) && (pst[1] == 0) && (pst[2] == 0) && (pst[3] == 0)
                   && last_fin_task;    // all idle flag must rise
        end
        if (enabled != n) begin
            $display("%s: %0d commands enabled, %0d generated", name, enabled, n);
            err_cnt++;
        end
        $display("test %s done: %0d commands, %0d errors", name, n, err_cnt - errs0);
    endtask

    initial begin
        cmd_in        = '0;
        empty_q       = 1'b1;
        busy          = '0;
        fin           = '0;
        fin_seen      = '0;
        err_cnt       = 0;
        cycles        = 0;
        limit         = 0;
        beat_left     = 0;
        beat_proc     = 0;
        beat_found    = 1'b0;
        last_fin_task = 1'b0;
        verdict_done  = 1'b0;
        next_id       = 5'd1;
        for (int i = 0; i < 4; i++) begin
            pst[i]      = 0;
            pcnt[i]     = 0;
            fl_valid[i] = 1'b0;
            fl_id[i]    = '0;
        end
        seed_dummy = $urandom(32'h9c0dc066);
        @(posedge rstn);
        run_test("independent", 12, 0);
        run_test("dependent_chain", 10, 1);
        run_test("random_mix", 40, 2);
        $display("tests run: 3, errors: %0d", err_cnt);
        verdict_done = 1'b1;
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/issuer_assert.sv
/*
    Issuer protocol assertions.
    Enable and ack never overlap and stay one-hot, and the queue is
    never read while empty.
*/
`timescale 1ns/1ps
`default_nettype none

module issuer_assert (
    input wire                          i_clk,
    input wire                          i_rstn,
    input wire issuer_pkg::proc_mask_t  i_en_proc,
    input wire issuer_pkg::proc_mask_t  i_ack_proc,
    input wire                          i_rd_queue,
    input wire                          i_empty_queue
);

    a_en_ack_apart: assert property (@(posedge i_clk) disable iff (!i_rstn)
        !((|i_en_proc) && (|i_ack_proc)))
        else $error("enable and ack active together");

    a_en_onehot: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $onehot0(i_en_proc))
        else $error("enable mask not one-hot");

    a_ack_onehot: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $onehot0(i_ack_proc))
        else $error("ack mask not one-hot");

    a_rd_not_empty: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_rd_queue |-> !i_empty_queue)
        else $error("queue read while empty");

endmodule

bind issuer_top issuer_assert u_assert (
    .i_clk(i_clk), .i_rstn(i_rstn), .i_en_proc(o_en_proc), .i_ack_proc(o_ack_proc),
    .i_rd_queue(o_rd_queue), .i_empty_queue(i_empty_queue)
);

`default_nettype wire

//--- testbench/tb_clkgen.sv
/*
    Testbench clock and reset.
    4 ns clock, active-low reset held for the first 5 cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_rstn
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;   // 4 ns period
    end

    initial begin
        o_rstn = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_rstn = 1'b1;            // release off the edge
    end

endmodule

`default_nettype wire

//--- source/issuer_top.sv
/*
    Command issuer top level.
    Ties the controller to the in-flight table, the dependency FIFO
    and the processor driver.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issuer_macros.svh"

module issuer_top (
    input  wire                          i_clk,
    input  wire                          i_rstn,
    input  wire issuer_pkg::cmd_t        i_cmd,          // queue head, valid when not empty
    input  wire                          i_empty_queue,
    output logic                         o_rd_queue,
    input  wire issuer_pkg::proc_mask_t  i_busy_proc,
    input  wire issuer_pkg::proc_mask_t  i_finish_proc,  // held until acked
    output issuer_pkg::proc_mask_t       o_en_proc,
    output issuer_pkg::proc_mask_t       o_ack_proc,
    output issuer_pkg::instr_t           o_instr,
    output logic                         o_finished_task
);

    // table side
    logic                               id_hit, tab_full, tab_empty, insert, delete;
    issuer_pkg::proc_mask_t             proc_held;
    issuer_pkg::cmd_id_t                look_id, ins_id;
    issuer_pkg::proc_idx_t              ins_proc, del_proc;
    // fifo side
    issuer_pkg::cmd_t                   fifo_head, park_cmd;
    logic                               fifo_full, fifo_empty, push, pop;
    logic [$clog2(`ISSUER_MAX_CMDS):0]  fifo_count;
    // driver side
    logic                               start, flush, drv_done;
    issuer_pkg::cmd_info_t              info;
    issuer_pkg::proc_idx_t              proc;

    issue_ctrl u_ctrl (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_cmd(i_cmd), .i_empty_queue(i_empty_queue),
        .i_busy_proc(i_busy_proc), .i_finish_proc(i_finish_proc), .i_id_hit(id_hit),
        .i_proc_held(proc_held), .i_tab_full(tab_full), .i_tab_empty(tab_empty),
        .i_fifo_head(fifo_head), .i_fifo_full(fifo_full), .i_fifo_empty(fifo_empty),
        .i_fifo_count(fifo_count), .i_drv_done(drv_done), .o_rd_queue(o_rd_queue),
        .o_look_id(look_id), .o_insert(insert), .o_ins_id(ins_id), .o_ins_proc(ins_proc),
        .o_delete(delete), .o_del_proc(del_proc), .o_push(push), .o_pop(pop),
        .o_park_cmd(park_cmd), .o_start(start), .o_info(info), .o_proc(proc),
        .o_flush(flush), .o_finished_task(o_finished_task)
    );

    inflight_table u_table (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_insert(insert), .i_ins_id(ins_id),
        .i_ins_proc(ins_proc), .i_delete(delete), .i_del_proc(del_proc),
        .i_look_id(look_id), .o_id_hit(id_hit), .o_proc_held(proc_held),
        .o_full(tab_full), .o_empty(tab_empty)
    );

    dep_fifo #(.T_DATA(issuer_pkg::cmd_t), .DEPTH(`ISSUER_MAX_CMDS)) u_fifo (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_push(push), .i_pop(pop), .i_data(park_cmd),
        .o_data(fifo_head), .o_full(fifo_full), .o_empty(fifo_empty), .o_count(fifo_count)
    );

    proc_driver u_driver (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_start(start), .i_info(info), .i_proc(proc),
        .i_flush(flush), .i_flush_proc(proc), .o_en_proc(o_en_proc),
        .o_ack_proc(o_ack_proc), .o_instr(o_instr), .o_done(drv_done)
    );

endmodule

`default_nettype wire

//--- source/issue_ctrl.sv
/*
    Issue controller.
    Reads commands from the queue or the dependency FIFO, checks the
    dependency against the in-flight table, then issues or parks.
    Finishing processors are acked first and trigger one retry pass
    over the parked commands.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issuer_macros.svh"

module issue_ctrl (
    input  wire                                 i_clk,
    input  wire                                 i_rstn,
    input  wire issuer_pkg::cmd_t               i_cmd,
    input  wire                                 i_empty_queue,
    input  wire issuer_pkg::proc_mask_t         i_busy_proc,
    input  wire issuer_pkg::proc_mask_t         i_finish_proc,
    input  wire                                 i_id_hit,
    input  wire issuer_pkg::proc_mask_t         i_proc_held,
    input  wire                                 i_tab_full,
    input  wire                                 i_tab_empty,
    input  wire issuer_pkg::cmd_t               i_fifo_head,
    input  wire                                 i_fifo_full,
    input  wire                                 i_fifo_empty,
    input  wire [$clog2(`ISSUER_MAX_CMDS):0]    i_fifo_count,
    input  wire                                 i_drv_done,
    output logic                                o_rd_queue,
    output issuer_pkg::cmd_id_t                 o_look_id,
    output logic                                o_insert,
    output issuer_pkg::cmd_id_t                 o_ins_id,
    output issuer_pkg::proc_idx_t               o_ins_proc,
    output logic                                o_delete,
    output issuer_pkg::proc_idx_t               o_del_proc,
    output logic                                o_push,
    output logic                                o_pop,
    output issuer_pkg::cmd_t                    o_park_cmd,
    output logic                                o_start,
    output issuer_pkg::cmd_info_t               o_info,
    output issuer_pkg::proc_idx_t               o_proc,
    output logic                                o_flush,
    output logic                                o_finished_task
);

    typedef enum logic [2:0] {IDLE, CHECK, ISSUE, PARK, FINISH} state_e;

    state_e                              state;
    issuer_pkg::cmd_t                    cur_cmd;    // command under check
    issuer_pkg::proc_idx_t               sel_proc;   // target of issue or of flush
    logic [$clog2(`ISSUER_MAX_CMDS):0]   retry_cnt;  // parked commands still to re-examine
    issuer_pkg::proc_mask_t              free_mask;
    logic                                fin_any;
    logic                                can_issue;
    logic                                take_pop;
    logic                                take_queue;

    assign fin_any   = |i_finish_proc;
    assign free_mask = ~(i_busy_proc | i_proc_held);  // idle and not owned by a table entry
    assign can_issue = (|free_mask) && !i_tab_full;

    // finish beats both reads, retry pop beats a queue read
    assign take_pop   = (state == IDLE) && !fin_any && can_issue
                        && (retry_cnt != '0) && !i_fifo_empty;
    assign take_queue = (state == IDLE) && !fin_any && can_issue && !take_pop
                        && !i_empty_queue && !i_fifo_full;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state     <= IDLE;
            retry_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fin_any) begin
                        state     <= FINISH;
                        retry_cnt <= i_fifo_count;  // every parked command gets one look
                    end else if (take_pop) begin
                        state     <= CHECK;
                        retry_cnt <= retry_cnt - 1'b1;
                    end else if (take_queue) begin
                        state <= CHECK;
                    end
                end
                CHECK:   state <= i_id_hit ? PARK : ISSUE;
                ISSUE:   if (i_drv_done) state <= IDLE;  // wait for the STORE beat
                PARK:    state <= IDLE;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == IDLE && fin_any) begin
            sel_proc <= issuer_pkg::first_set(i_finish_proc);
        end else if (take_pop || take_queue) begin
            sel_proc <= issuer_pkg::first_set(free_mask);    // lowest free processor
            cur_cmd  <= take_pop ? i_fifo_head : i_cmd;
        end
    end

    assign o_rd_queue = take_queue;   // pops the queue, i_cmd taken this cycle
    assign o_pop      = take_pop;
    assign o_look_id  = cur_cmd.dep;

    // table insert and driver start share the check cycle
    assign o_insert   = (state == CHECK) && !i_id_hit;
    assign o_ins_id   = cur_cmd.id;
    assign o_ins_proc = sel_proc;
    assign o_start    = (state == CHECK) && !i_id_hit;
    assign o_info     = cur_cmd.info;

    assign o_flush    = (state == IDLE) && fin_any;
    assign o_proc     = (state == IDLE) ? issuer_pkg::first_set(i_finish_proc) : sel_proc;
    assign o_delete   = (state == FINISH);
    assign o_del_proc = sel_proc;

    assign o_push     = (state == PARK);
    assign o_park_cmd = cur_cmd;

    assign o_finished_task = (state == IDLE) && !(|i_busy_proc) && i_tab_empty && i_fifo_empty;

endmodule

`default_nettype wire

//--- source/proc_driver.sv
/*
    Processor driver.
    Sends the enable pulse and the four instruction beats of an issued
    command, and the ack that releases a finished processor.
*/
`timescale 1ns/1ps
`default_nettype none

module proc_driver (
    input  wire                          i_clk,
    input  wire                          i_rstn,
    input  wire                          i_start,
    input  wire issuer_pkg::cmd_info_t   i_info,
    input  wire issuer_pkg::proc_idx_t   i_proc,
    input  wire                          i_flush,
    input  wire issuer_pkg::proc_idx_t   i_flush_proc,
    output issuer_pkg::proc_mask_t       o_en_proc,
    output issuer_pkg::proc_mask_t       o_ack_proc,
    output issuer_pkg::instr_t           o_instr,
    output logic                         o_done
);

    localparam logic [2:0] B_IDLE = 3'd0, B_EN = 3'd1, B_LD0 = 3'd2;
    localparam logic [2:0] B_LD1 = 3'd3, B_INFO = 3'd4, B_STORE = 3'd5;

    logic [2:0]              beat;
    issuer_pkg::cmd_info_t   info_q;
    issuer_pkg::proc_idx_t   proc_q;
    logic                    flush_q;
    issuer_pkg::proc_idx_t   flush_proc_q;
    issuer_pkg::proc_mask_t  proc_mask;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            beat    <= B_IDLE;
            flush_q <= 1'b0;
        end else begin
            if (i_start) beat <= B_EN;
            else if (beat != B_IDLE) beat <= (beat == B_STORE) ? B_IDLE : beat + 3'd1;
            flush_q <= i_flush;  // ack one cycle after the flush strobe
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            info_q <= i_info;
            proc_q <= i_proc;
        end
        if (i_flush) flush_proc_q <= i_flush_proc;
    end

    assign proc_mask = issuer_pkg::proc_mask_t'(1) << proc_q;

    always_comb begin
        o_en_proc  = (beat == B_EN) ? proc_mask : '0;
        o_ack_proc = (beat >= B_LD0) ? proc_mask : '0;      // one ack per beat
        if (flush_q) o_ack_proc = o_ack_proc | (issuer_pkg::proc_mask_t'(1) << flush_proc_q);
        o_instr.opcode  = issuer_pkg::NONE;
        o_instr.payload = '0;
        case (beat)
            B_LD0:   begin o_instr.opcode = issuer_pkg::LD;    o_instr.payload = info_q.addr_0; end
            B_LD1:   begin o_instr.opcode = issuer_pkg::LD;    o_instr.payload = info_q.addr_1; end
            B_INFO:  begin o_instr.opcode = issuer_pkg::INFO;  o_instr.payload = {info_q.op, info_q.count}; end
            B_STORE: begin o_instr.opcode = issuer_pkg::STORE; o_instr.payload = info_q.wr_addr; end
            default: ;
        endcase
    end

    assign o_done = (beat == B_STORE);  // last beat

endmodule

`default_nettype wire

//--- source/inflight_table.sv
/*
    In-flight table.
    Holds {command id, processor} pairs of issued commands.
    Lookup by id and by processor is combinational, insert takes the
    lowest free slot and delete frees the slot owned by a processor.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issuer_macros.svh"

module inflight_table (
    input  wire                          i_clk,
    input  wire                          i_rstn,
    input  wire                          i_insert,
    input  wire issuer_pkg::cmd_id_t     i_ins_id,
    input  wire issuer_pkg::proc_idx_t   i_ins_proc,
    input  wire                          i_delete,
    input  wire issuer_pkg::proc_idx_t   i_del_proc,
    input  wire issuer_pkg::cmd_id_t     i_look_id,
    output logic                         o_id_hit,
    output issuer_pkg::proc_mask_t       o_proc_held,
    output logic                         o_full,
    output logic                         o_empty
);

    localparam int N = `ISSUER_MAX_CMDS;

    issuer_pkg::tab_entry_t  tab [N];   // slot contents
    logic [N-1:0]            valid;     // slot occupied
    logic [$clog2(N)-1:0]    free_slot;
    logic [N-1:0]            del_hit;   // slots owned by i_del_proc

    always_comb begin
        free_slot   = '0;
        o_id_hit    = 1'b0;
        o_proc_held = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!valid[i]) free_slot = ($clog2(N))'(i);  // lowest free ends up last
        end
        for (int i = 0; i < N; i++) begin
            del_hit[i] = valid[i] && (tab[i].proc == i_del_proc);
            if (valid[i] && tab[i].id == i_look_id) o_id_hit = 1'b1;  // id 0 never stored
            if (valid[i]) o_proc_held[tab[i].proc] = 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            valid <= '0;
        end else begin
            if (i_delete) valid <= valid & ~del_hit;
            else if (i_insert && !o_full) valid[free_slot] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_insert && !i_delete && !o_full) begin
            tab[free_slot].id   <= i_ins_id;
            tab[free_slot].proc <= i_ins_proc;
        end
    end

    assign o_full  = &valid;
    assign o_empty = ~|valid;

endmodule

`default_nettype wire

//--- source/dep_fifo.sv
/*
    Dependency FIFO.
    Circular buffer for commands whose dependency is still in flight.
    Head is visible combinationally, push and pop act on the next edge.
*/
`timescale 1ns/1ps
`default_nettype none
`include "issuer_macros.svh"

module dep_fifo #(
    parameter type T_DATA = logic [7:0],
    parameter int  DEPTH  = `ISSUER_MAX_CMDS
) (
    input  wire                     i_clk,
    input  wire                     i_rstn,
    input  wire                     i_push,
    input  wire                     i_pop,
    input  wire T_DATA              i_data,
    output T_DATA                   o_data,
    output logic                    o_full,
    output logic                    o_empty,
    output logic [$clog2(DEPTH):0]  o_count
);

    localparam int PTR_W = $clog2(DEPTH);

    T_DATA            mem [DEPTH];      // parked payloads
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;            // occupancy
    logic             do_push;
    logic             do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr] <= i_data;  // retries re-enter at the tail
    end

    assign o_data  = mem[rd_ptr];
    assign o_full  = (count == (PTR_W + 1)'(DEPTH));
    assign o_empty = (count == '0);
    assign o_count = count;

endmodule

`default_nettype wire

//--- source/issuer_pkg.sv
/*
    Command issuer types.
    Command, instruction, processor and table types, plus a
    lowest-set-bit helper for processor masks.
*/
`default_nettype none
`include "issuer_macros.svh"

package issuer_pkg;

    typedef logic [`ISSUER_ID_W-1:0]                cmd_id_t;
    typedef logic [$clog2(`ISSUER_PROC_COUNT)-1:0]  proc_idx_t;
    typedef logic [`ISSUER_PROC_COUNT-1:0]          proc_mask_t; // one bit per processor

    typedef struct packed {
        logic [`ISSUER_OP_W-1:0]    op;
        logic [`ISSUER_ADDR_W-1:0]  addr_0;   // first load
        logic [`ISSUER_ADDR_W-1:0]  addr_1;   // second load
        logic [`ISSUER_ADDR_W-1:0]  wr_addr;  // writeback
        logic [`ISSUER_COUNT_W-1:0] count;
    } cmd_info_t;

    typedef struct packed {
        cmd_id_t   id;
        cmd_id_t   dep;   // 0 when independent
        cmd_info_t info;
    } cmd_t;

    typedef enum logic [1:0] {NONE, LD, INFO, STORE} instr_op_e;

    typedef struct packed {
        instr_op_e                 opcode;
        logic [`ISSUER_ADDR_W-1:0] payload;  // INFO beats carry {op, count}
    } instr_t;

    // one in-flight table slot, the valid bit lives beside it
    typedef struct packed {
        cmd_id_t   id;
        proc_idx_t proc;
    } tab_entry_t;

    function automatic proc_idx_t first_set(input proc_mask_t mask);
        proc_idx_t idx;
        idx = '0;
        for (int i = `ISSUER_PROC_COUNT - 1; i >= 0; i--) begin
            if (mask[i]) idx = proc_idx_t'(i);  // lower index wins
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

//--- source/issuer_macros.svh
/*
    Command issuer sizing.
    Processor count, in-flight depth and field widths shared by the
    package and the RTL.
*/
`ifndef ISSUER_MACROS_SVH
`define ISSUER_MACROS_SVH

`define ISSUER_PROC_COUNT 4   // processors in the SIMD array
`define ISSUER_MAX_CMDS   8   // in-flight table entries and FIFO depth

`define ISSUER_ID_W       5   // command id, 0 means no dependency
`define ISSUER_ADDR_W     8   // addresses and instruction payload
`define ISSUER_OP_W       3   // opcode of a command
`define ISSUER_COUNT_W    5   // element count of a command

`endif
